//--- aes_cipher_ctrl.f
+incdir+tb
verilog/aes_ctrl_pkg.sv
verilog/aes_sp2v_check.sv
verilog/aes_ctrl_rail_p.sv
verilog/aes_ctrl_rail_n.sv
verilog/aes_ctrl_combine.sv
verilog/aes_cipher_ctrl.sv
tb/aes_cipher_ctrl_tb.sv

//--- Makefile
TOP  := aes_cipher_ctrl_tb
PASS := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f aes_cipher_ctrl.f --top-module aes_cipher_ctrl

sim:
	verilator --binary --timing -f aes_cipher_ctrl.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

//--- tb/aes_ctrl_checks.svh
//////////////////////////////////////////////////////////////////////
// Round reference model and compare tasks
//////////////////////////////////////////////////////////////////////

`ifndef AES_CTRL_CHECKS_SVH
`define AES_CTRL_CHECKS_SVH

// Rounds per key length as given by the AES standard
function automatic int exp_rounds(input key_len_e len);
  case (len)
    KEY_192: return 12;
    KEY_256: return 14;
    default: return 10;
  endcase
endfunction

// Round key source for enabled cycle cyc (1 to n) of a block
function automatic add_rk_sel_e exp_rk_sel(input int cyc, input int n);
  if (cyc == 1) return ADD_RK_INIT;
  if (cyc == n) return ADD_RK_FINAL;
  return ADD_RK_ROUND;
endfunction

task automatic check_sp2v(input sp2v_e act, input sp2v_e exp, input string what);
  if (act !== exp) begin
    $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
    err_cnt++;
  end
endtask

task automatic check_rk_sel(input add_rk_sel_e act, input add_rk_sel_e exp,
                            input string what);
  if (act !== exp) begin
    $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
    err_cnt++;
  end
endtask

task automatic check_round(input logic [RndCtrWidth-1:0] act,
                           input logic [RndCtrWidth-1:0] exp, input string what);
  if (act !== exp) begin
    $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, act, exp);
    err_cnt++;
  end
endtask

task automatic check_bit(input logic act, input logic exp, input string what);
  if (act !== exp) begin
    $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
    err_cnt++;
  end
endtask

`endif

//--- tb/aes_cipher_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// AES round controller testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module aes_cipher_ctrl_tb import aes_ctrl_pkg::*; ();

  typedef enum {W_READY, W_VALID, W_ALERT} wait_e;

  logic                   clk_i, rst_ni;
  sp2v_e                  in_valid_i, in_ready_o, out_valid_o, out_ready_i, state_we_o;
  key_len_e               key_len_i;
  add_rk_sel_e            add_rk_sel_o;
  logic [RndCtrWidth-1:0] round_o;
  logic                   alert_o;

  int err_cnt, tests_run, tests_failed, seed;
  bit timed_out, check_en;
  bit mon_active, mon_taken;
  int mon_cyc, mon_n;

  `include "aes_ctrl_checks.svh"

  aes_cipher_ctrl u_aes_cipher_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .in_valid_i   ( in_valid_i   ),
    .in_ready_o   ( in_ready_o   ),
    .key_len_i    ( key_len_i    ),
    .out_valid_o  ( out_valid_o  ),
    .out_ready_i  ( out_ready_i  ),
    .state_we_o   ( state_we_o   ),
    .add_rk_sel_o ( add_rk_sel_o ),
    .round_o      ( round_o      ),
    .alert_o      ( alert_o      )
  );

  initial begin : gen_clock
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Comparison process sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare_outputs
    if (!rst_ni || !check_en) begin
      mon_active = 1'b0;
      mon_taken  = 1'b0;
    end else begin
      if (mon_taken) begin  // Cycle after the result was taken
        check_sp2v(in_ready_o, SP2V_HIGH, "in_ready_o after take");
        check_sp2v(out_valid_o, SP2V_LOW, "out_valid_o after take");
        check_rk_sel(add_rk_sel_o, ADD_RK_INIT, "add_rk_sel_o in idle");
        mon_taken = 1'b0;
      end
      if (mon_active) begin
        mon_cyc++;
        if (mon_cyc <= mon_n) begin
          check_sp2v(state_we_o, SP2V_HIGH, "state_we_o in block");
          check_sp2v(out_valid_o, SP2V_LOW, "out_valid_o in block");
          check_sp2v(in_ready_o, SP2V_LOW, "in_ready_o in block");
          check_round(round_o, RndCtrWidth'(mon_cyc - 1), "round_o");
          check_rk_sel(add_rk_sel_o, exp_rk_sel(mon_cyc, mon_n), "add_rk_sel_o");
        end else begin
          check_sp2v(out_valid_o, SP2V_HIGH, "out_valid_o at finish");
          check_sp2v(state_we_o, SP2V_LOW, "state_we_o at finish");
          check_sp2v(in_ready_o, SP2V_LOW, "in_ready_o at finish");
          check_rk_sel(add_rk_sel_o, ADD_RK_INIT, "add_rk_sel_o at finish");
          if (out_ready_i == SP2V_HIGH) begin
            mon_active = 1'b0;
            mon_taken  = 1'b1;
          end
        end
        check_bit(alert_o, 1'b0, "alert_o in block");
      end else if (in_valid_i == SP2V_HIGH && in_ready_o == SP2V_HIGH) begin
        mon_active = 1'b1;  // Accepted at the coming edge
        mon_cyc    = 0;
        mon_n      = exp_rounds(key_len_i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic wait_for(input wait_e what, input int limit);
    int cnt;
    bit hit;
    cnt = 0;
    hit = 1'b0;
    while (!hit && cnt < limit) begin
      @(negedge clk_i);
      cnt++;
      case (what)
        W_READY: hit = (in_ready_o === SP2V_HIGH);
        W_VALID: hit = (out_valid_o === SP2V_HIGH);
        default: hit = (alert_o === 1'b1);
      endcase
    end
    if (!hit) begin
      $display("Timeout: %s not seen within %0d cycles", what.name(), limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni      <= 1'b0;
    in_valid_i  <= SP2V_LOW;
    out_ready_i <= SP2V_HIGH;
    key_len_i   <= KEY_128;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // One block with the sink stalling for stall cycles once the result is up
  task automatic run_block(input key_len_e len, input int stall);
    int i;
    wait_for(W_READY, 50);
    if (timed_out) return;
    @(posedge clk_i);
    in_valid_i <= SP2V_HIGH;
    key_len_i  <= len;
    if (stall > 0) out_ready_i <= SP2V_LOW;
    @(posedge clk_i);  // Accepting edge
    in_valid_i <= SP2V_LOW;
    wait_for(W_VALID, 50);
    if (timed_out) return;
    for (i = 0; i < stall; i++) begin
      check_sp2v(out_valid_o, SP2V_HIGH, "out_valid_o under back-pressure");
      check_sp2v(in_ready_o, SP2V_LOW, "in_ready_o under back-pressure");
      if (i < stall - 1) @(negedge clk_i);
    end
    if (stall > 0) begin
      @(posedge clk_i);
      out_ready_i <= SP2V_HIGH;
    end
  endtask

  // Bad valid code mid-block followed by a fresh reset and one clean block
  task automatic run_error(input sp2v_e bad);
    @(posedge clk_i);
    check_en = 1'b0;
    in_valid_i <= SP2V_HIGH;
    key_len_i  <= KEY_256;
    @(posedge clk_i);
    in_valid_i <= SP2V_LOW;
    repeat (3) @(posedge clk_i);
    in_valid_i <= bad;
    wait_for(W_ALERT, 2);
    if (timed_out) return;
    @(posedge clk_i);
    in_valid_i <= SP2V_LOW;
    repeat (5) begin
      @(negedge clk_i);
      check_bit(alert_o, 1'b1, "alert_o after error");
      check_sp2v(out_valid_o, SP2V_LOW, "out_valid_o in error");
      check_sp2v(in_ready_o, SP2V_LOW, "in_ready_o in error");
      check_sp2v(state_we_o, SP2V_LOW, "state_we_o in error");
    end
    apply_reset();
    check_en = 1'b1;
    run_block(KEY_128, 0);
    if (!timed_out) wait_for(W_READY, 50);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before || timed_out) begin
      tests_failed++;
      $display("Test %s: failed", name);
    end else begin
      $display("Test %s: passed", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    int errs, k, pick;
    key_len_e len;
    seed        = 32'h355f;
    rst_ni      = 1'b0;
    in_valid_i  = SP2V_LOW;
    out_ready_i = SP2V_HIGH;
    key_len_i   = KEY_128;
    check_en    = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    errs = err_cnt;
    @(negedge clk_i);
    check_sp2v(in_ready_o, SP2V_HIGH, "in_ready_o after reset");
    check_sp2v(out_valid_o, SP2V_LOW, "out_valid_o after reset");
    check_sp2v(state_we_o, SP2V_LOW, "state_we_o after reset");
    check_bit(alert_o, 1'b0, "alert_o after reset");
    check_round(round_o, '0, "round_o after reset");
    report_test("reset values", errs);
    @(posedge clk_i);
    check_en = 1'b1;

    for (k = 0; k < 3; k++) begin
      errs = err_cnt;
      len  = key_len_e'(k[1:0]);
      if (!timed_out) run_block(len, 0);
      if (!timed_out) wait_for(W_READY, 50);
      report_test($sformatf("block %s", len.name()), errs);
    end

    errs = err_cnt;
    for (k = 0; k < 20; k++) begin
      pick = $unsigned($random(seed)) % 3;
      if (!timed_out) run_block(key_len_e'(pick[1:0]), 0);
    end
    if (!timed_out) wait_for(W_READY, 50);
    report_test("random lengths", errs);

    errs = err_cnt;
    for (k = 0; k < 4; k++) begin
      pick = $unsigned($random(seed)) % 3;
      if (!timed_out) run_block(key_len_e'(pick[1:0]), 1 + $unsigned($random(seed)) % 10);
    end
    if (!timed_out) wait_for(W_READY, 50);
    report_test("back-pressure", errs);

    errs = err_cnt;
    if (!timed_out) run_error(sp2v_e'(2'b11));
    report_test("error code 11", errs);
    errs = err_cnt;
    if (!timed_out) run_error(sp2v_e'(2'b00));
    report_test("error code 00", errs);

    $display("Tests run: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/aes_cipher_ctrl.sv
//////////////////////////////////////////////////////////////////////
// AES cipher round controller
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module aes_cipher_ctrl import aes_ctrl_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  sp2v_e                  in_valid_i,
  output sp2v_e                  in_ready_o,
  input  key_len_e               key_len_i,

  output sp2v_e                  out_valid_o,
  input  sp2v_e                  out_ready_i,

  output sp2v_e                  state_we_o,
  output add_rk_sel_e            add_rk_sel_o,
  output logic [RndCtrWidth-1:0] round_o,
  output logic                   alert_o
);

  sp2v_u                                 in_valid_u, out_ready_u;
  sp2v_e       [1:0]                     chk_sig;
  logic                                  enc_err, mismatch, err;
  logic                                  in_ready_p, out_valid_p, state_we_p;
  logic                                  in_ready_n, out_valid_n, state_we_n;
  add_rk_sel_e [Sp2VWidth-1:0]           mr_add_rk_sel;
  logic        [Sp2VWidth-1:0][RndCtrWidth-1:0] mr_rnd_ctr;
  logic        [Sp2VWidth-1:0]           mr_alert;

  // Split sparse inputs into rail bits
  always_comb begin : split_inputs
    in_valid_u.code  = in_valid_i;
    out_ready_u.code = out_ready_i;
    chk_sig[0]       = in_valid_i;
    chk_sig[1]       = out_ready_i;
  end

  aes_sp2v_check #(
    .NumSig ( 2 )
  ) u_sp2v_check (
    .sig_i ( chk_sig ),
    .err_o ( enc_err )
  );

  // Rails only expose registered state, so no loop through err
  assign err = enc_err | mismatch;

  aes_ctrl_rail_p u_rail_p (
    .clk_i        ( clk_i                   ),
    .rst_ni       ( rst_ni                  ),
    .in_valid_i   ( in_valid_u.rail.rail_p  ),
    .in_ready_o   ( in_ready_p              ),
    .out_valid_o  ( out_valid_p             ),
    .out_ready_i  ( out_ready_u.rail.rail_p ),
    .key_len_i    ( key_len_i               ),
    .err_i        ( err                     ),
    .state_we_o   ( state_we_p              ),
    .add_rk_sel_o ( mr_add_rk_sel[0]        ),
    .rnd_ctr_o    ( mr_rnd_ctr[0]           ),
    .alert_o      ( mr_alert[0]             )
  );

  aes_ctrl_rail_n u_rail_n (
    .clk_i        ( clk_i                   ),
    .rst_ni       ( rst_ni                  ),
    .in_valid_ni  ( in_valid_u.rail.rail_n  ),  // Active low
    .in_ready_no  ( in_ready_n              ),
    .out_valid_no ( out_valid_n             ),
    .out_ready_ni ( out_ready_u.rail.rail_n ),
    .key_len_i    ( key_len_i               ),
    .err_i        ( err                     ),
    .state_we_no  ( state_we_n              ),
    .add_rk_sel_o ( mr_add_rk_sel[1]        ),
    .rnd_ctr_o    ( mr_rnd_ctr[1]           ),
    .alert_o      ( mr_alert[1]             )
  );

  aes_ctrl_combine u_combine (
    .in_ready_p_i  ( in_ready_p    ),
    .out_valid_p_i ( out_valid_p   ),
    .state_we_p_i  ( state_we_p    ),
    .in_ready_n_i  ( in_ready_n    ),
    .out_valid_n_i ( out_valid_n   ),
    .state_we_n_i  ( state_we_n    ),
    .add_rk_sel_i  ( mr_add_rk_sel ),
    .rnd_ctr_i     ( mr_rnd_ctr    ),
    .alert_i       ( mr_alert      ),
    .in_ready_o    ( in_ready_o    ),
    .out_valid_o   ( out_valid_o   ),
    .state_we_o    ( state_we_o    ),
    .add_rk_sel_o  ( add_rk_sel_o  ),
    .round_o       ( round_o       ),
    .alert_o       ( alert_o       ),
    .mismatch_o    ( mismatch      )
  );

endmodule

//--- verilog/aes_ctrl_combine.sv
//////////////////////////////////////////////////////////////////////
// Rail output combiner
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module aes_ctrl_combine import aes_ctrl_pkg::*; (
  // Rail bits, index 0 is the p-rail and index 1 the n-rail
  input  logic                                  in_ready_p_i,
  input  logic                                  out_valid_p_i,
  input  logic                                  state_we_p_i,
  input  logic                                  in_ready_n_i,
  input  logic                                  out_valid_n_i,
  input  logic                                  state_we_n_i,
  input  add_rk_sel_e [Sp2VWidth-1:0]           add_rk_sel_i,
  input  logic [Sp2VWidth-1:0][RndCtrWidth-1:0] rnd_ctr_i,
  input  logic [Sp2VWidth-1:0]                  alert_i,

  output sp2v_e                                 in_ready_o,
  output sp2v_e                                 out_valid_o,
  output sp2v_e                                 state_we_o,
  output add_rk_sel_e                           add_rk_sel_o,
  output logic [RndCtrWidth-1:0]                round_o,
  output logic                                  alert_o,
  output logic                                  mismatch_o
);

  sp2v_u in_ready_u, out_valid_u, state_we_u;

  //////////////////////////////////////////////////////////////////////
  // Sparse outputs
  //////////////////////////////////////////////////////////////////////

  // Disagreeing rails give 2'b00 or 2'b11 here
  always_comb begin : pack_sparse
    in_ready_u.rail.rail_p  = in_ready_p_i;
    in_ready_u.rail.rail_n  = in_ready_n_i;
    out_valid_u.rail.rail_p = out_valid_p_i;
    out_valid_u.rail.rail_n = out_valid_n_i;
    state_we_u.rail.rail_p  = state_we_p_i;
    state_we_u.rail.rail_n  = state_we_n_i;
  end

  assign in_ready_o  = in_ready_u.code;
  assign out_valid_o = out_valid_u.code;
  assign state_we_o  = state_we_u.code;

  //////////////////////////////////////////////////////////////////////
  // Multi-rail outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin : combine_rails
    logic [2:0] sel_or;
    logic [RndCtrWidth-1:0] ctr_or;

    sel_or = '0;
    ctr_or = '0;
    for (int i = 0; i < Sp2VWidth; i++) begin
      sel_or |= add_rk_sel_i[i];
      ctr_or |= rnd_ctr_i[i];
    end
    add_rk_sel_o = add_rk_sel_e'(sel_or);
    round_o      = ctr_or;

    // A rail that differs from the OR result was not the only one set
    mismatch_o = 1'b0;
    for (int i = 0; i < Sp2VWidth; i++) begin
      if (add_rk_sel_o != add_rk_sel_i[i] || round_o != rnd_ctr_i[i]) begin
        mismatch_o = 1'b1;
      end
    end
  end

  assign alert_o = |alert_i;  // One rail is enough

endmodule

//--- verilog/aes_ctrl_rail_n.sv
//////////////////////////////////////////////////////////////////////
// Round control FSM, active-low rail
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module aes_ctrl_rail_n import aes_ctrl_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   in_valid_ni,
  output logic                   in_ready_no,
  output logic                   out_valid_no,
  input  logic                   out_ready_ni,

  input  key_len_e               key_len_i,
  input  logic                   err_i,

  output logic                   state_we_no,
  output add_rk_sel_e            add_rk_sel_o,
  output logic [RndCtrWidth-1:0] rnd_ctr_o,
  output logic                   alert_o
);

  ctrl_state_e            state_d, state_q;
  logic [RndCtrWidth-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [RndCtrWidth-1:0] last_rnd_d, last_rnd_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  // Same sequence as the p-rail, handshake bits read inverted
  always_comb begin : next_state
    state_d    = state_q;
    rnd_ctr_d  = rnd_ctr_q;
    last_rnd_d = last_rnd_q;

    case (state_q)
      IDLE: begin
        if (!in_valid_ni) begin  // Valid is low on this rail
          state_d   = INIT;
          rnd_ctr_d = '0;
          case (key_len_i)
            KEY_192: last_rnd_d = RndCtrWidth'(NumRounds192 - 1);
            KEY_256: last_rnd_d = RndCtrWidth'(NumRounds256 - 1);
            default: last_rnd_d = RndCtrWidth'(NumRounds128 - 1);
          endcase
        end
      end
      INIT: begin
        state_d   = ROUND;
        rnd_ctr_d = rnd_ctr_q + 1'b1;
      end
      ROUND: begin
        rnd_ctr_d = rnd_ctr_q + 1'b1;
        if (rnd_ctr_q == last_rnd_q - 1'b1) state_d = FINAL;
      end
      FINAL: begin
        state_d   = FINISH;
        rnd_ctr_d = '0;
      end
      FINISH: begin
        if (!out_ready_ni) state_d = IDLE;
      end
      ERROR:   state_d = ERROR;
      default: state_d = ERROR;  // Illegal encoding
    endcase

    if (err_i) begin
      state_d   = ERROR;
      rnd_ctr_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_state
    if (!rst_ni) begin
      state_q    <= IDLE;
      rnd_ctr_q  <= '0;
      last_rnd_q <= '0;
    end else begin
      state_q    <= state_d;
      rnd_ctr_q  <= rnd_ctr_d;
      last_rnd_q <= last_rnd_d;
    end
  end

  // Sparse outputs are active low
  assign in_ready_no  = (state_q != IDLE);
  assign out_valid_no = (state_q != FINISH);
  assign state_we_no  = !(state_q inside {INIT, ROUND, FINAL});
  assign rnd_ctr_o    = rnd_ctr_q;
  assign alert_o      = (state_q == ERROR);

  always_comb begin : rk_sel
    case (state_q)
      ROUND:   add_rk_sel_o = ADD_RK_ROUND;
      FINAL:   add_rk_sel_o = ADD_RK_FINAL;
      default: add_rk_sel_o = ADD_RK_INIT;
    endcase
  end

endmodule

//--- verilog/aes_ctrl_rail_p.sv
//////////////////////////////////////////////////////////////////////
// Round control FSM, active-high rail
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module aes_ctrl_rail_p import aes_ctrl_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,

  input  key_len_e               key_len_i,
  input  logic                   err_i,

  output logic                   state_we_o,
  output add_rk_sel_e            add_rk_sel_o,
  output logic [RndCtrWidth-1:0] rnd_ctr_o,
  output logic                   alert_o
);

  ctrl_state_e            state_d, state_q;
  logic [RndCtrWidth-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [RndCtrWidth-1:0] last_rnd_d, last_rnd_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin : next_state
    state_d    = state_q;
    rnd_ctr_d  = rnd_ctr_q;
    last_rnd_d = last_rnd_q;

    case (state_q)
      IDLE: begin
        if (in_valid_i) begin
          state_d   = INIT;
          rnd_ctr_d = '0;
          case (key_len_i)
            KEY_192: last_rnd_d = RndCtrWidth'(NumRounds192 - 1);
            KEY_256: last_rnd_d = RndCtrWidth'(NumRounds256 - 1);
            default: last_rnd_d = RndCtrWidth'(NumRounds128 - 1);
          endcase
        end
      end
      INIT: begin
        state_d   = ROUND;
        rnd_ctr_d = rnd_ctr_q + 1'b1;
      end
      ROUND: begin
        rnd_ctr_d = rnd_ctr_q + 1'b1;
        if (rnd_ctr_q == last_rnd_q - 1'b1) begin
          state_d = FINAL;  // Next round is the last one
        end
      end
      FINAL: begin
        state_d   = FINISH;
        rnd_ctr_d = '0;
      end
      FINISH: begin
        if (out_ready_i) state_d = IDLE;  // Result taken
      end
      ERROR:   state_d = ERROR;  // Terminal
      default: state_d = ERROR;
    endcase

    // Any error wins over the normal sequence
    if (err_i) begin
      state_d   = ERROR;
      rnd_ctr_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_state
    if (!rst_ni) begin
      state_q    <= IDLE;
      rnd_ctr_q  <= '0;
      last_rnd_q <= '0;
    end else begin
      state_q    <= state_d;
      rnd_ctr_q  <= rnd_ctr_d;
      last_rnd_q <= last_rnd_d;
    end
  end

  // Outputs decoded from registered state only
  assign in_ready_o  = (state_q == IDLE);
  assign out_valid_o = (state_q == FINISH);
  assign state_we_o  = state_q inside {INIT, ROUND, FINAL};
  assign rnd_ctr_o   = rnd_ctr_q;
  assign alert_o     = (state_q == ERROR);

  always_comb begin : rk_sel
    case (state_q)
      ROUND:   add_rk_sel_o = ADD_RK_ROUND;
      FINAL:   add_rk_sel_o = ADD_RK_FINAL;
      default: add_rk_sel_o = ADD_RK_INIT;
    endcase
  end

endmodule

//--- verilog/aes_sp2v_check.sv
//////////////////////////////////////////////////////////////////////
// Sparse code checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module aes_sp2v_check import aes_ctrl_pkg::*; #(
  parameter int unsigned NumSig = 1
) (
  input  sp2v_e [NumSig-1:0] sig_i,
  output logic               err_o
);

  logic [NumSig-1:0] sig_err;

  // Only the two valid codes pass, 2'b00 and 2'b11 are flagged
  always_comb begin : check_codes
    for (int i = 0; i < NumSig; i++) begin
      sig_err[i] = !(sig_i[i] inside {SP2V_HIGH, SP2V_LOW});
    end
  end

  assign err_o = |sig_err;  // Any bad code

endmodule

//--- verilog/aes_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// AES cipher round control package
//////////////////////////////////////////////////////////////////////

package aes_ctrl_pkg;

  // Sparse boolean and round counter widths
  localparam int unsigned Sp2VWidth   = 2;
  localparam int unsigned RndCtrWidth = 4;

  // Rounds per key length
  localparam int unsigned NumRounds128 = 10;
  localparam int unsigned NumRounds192 = 12;
  localparam int unsigned NumRounds256 = 14;

  // Two-bit sparse boolean, the other two codes are invalid
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 2'b01,
    SP2V_LOW  = 2'b10
  } sp2v_e;

  // Per-rail view of one sparse word
  typedef struct packed {
    logic rail_n;  // Active low
    logic rail_p;  // Active high
  } sp2v_rail_t;

  typedef union packed {
    sp2v_e      code;
    sp2v_rail_t rail;
  } sp2v_u;

  typedef enum logic [1:0] {
    KEY_128 = 2'b00,
    KEY_192 = 2'b01,
    KEY_256 = 2'b10
  } key_len_e;

  // One-hot round key selector
  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    INIT   = 3'b011,
    ROUND  = 3'b101,
    FINAL  = 3'b110,
    FINISH = 3'b111,
    ERROR  = 3'b100
  } ctrl_state_e;

endpackage
